//--- build.f
+incdir+logic
logic/core_pkg.sv
logic/fetch_ctrl.sv
logic/decode_1st.sv
logic/decode_2nd.sv
logic/register_file.sv
logic/exec.sv
logic/core.sv
tb/core_chk.sv
tb/tb_core.sv

//--- tb/tb_core.sv
`default_nettype none

`include "core_consts.svh"

module tb_core import core_pkg::*;;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PROG_WORDS     = 400;
    localparam int TIMEOUT_CYCLES = 5000;

    logic      CLK = 1'b0;
    logic      RST = 1'b1;
    logic      mem_wait = 1'b0;
    logic      inst_rvalid = 1'b0;
    word_t     inst_rdata = '0;
    logic      inst_rden;
    word_t     inst_raddr;
    logic      wb_valid;
    reg_addr_t wb_rd;
    word_t     wb_data;
    word_t     wb_pc;

    word_t       prog [PROG_WORDS];
    word_t       exp_pc [$];
    word_t       exp_rd [$];
    word_t       exp_val [$];
    word_t       pend_addr [$];
    int unsigned pend_due [$];
    int unsigned cycle = 0;
    word_t       next_addr = `CORE_RESET_PC;
    int unsigned retired = 0;
    int unsigned value_errors = 0;
    int unsigned other_errors = 0;

    core i_core (
        .CLK         (CLK),
        .RST         (RST),
        .mem_wait    (mem_wait),
        .inst_rvalid (inst_rvalid),
        .inst_rdata  (inst_rdata),
        .inst_rden   (inst_rden),
        .inst_raddr  (inst_raddr),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .wb_pc       (wb_pc)
    );

    initial begin
        forever #5 CLK = ~CLK;
    end

    task automatic check_value(string what, word_t got, word_t expected);
        if (got !== expected) begin
            value_errors++;
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    // reference ALU straight from the ISA definitions
    function automatic word_t isa_alu(funct3_t f3, logic alt, word_t a, word_t b);
        word_t res;
        case (f3)
            3'b000: res = alt ? a - b : a + b;
            3'b001: res = a << b[4:0];
            3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: res = (a < b) ? 32'd1 : 32'd0;
            3'b100: res = a ^ b;
            3'b101: begin
                if (alt) res = $signed(a) >>> b[4:0];
                else res = a >> b[4:0];
            end
            3'b110: res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    // small register range keeps hazards frequent
    task automatic make_program();
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        funct3_t     f3;
        funct7_t     f7;
        logic [11:0] imm12;
        logic [6:0]  opc;
        for (int i = 0; i < PROG_WORDS; i++) begin
            rd = reg_addr_t'($urandom % 8);
            rs1 = reg_addr_t'($urandom % 8);
            rs2 = reg_addr_t'($urandom % 8);
            f3 = funct3_t'($urandom);
            imm12 = 12'($urandom);
            f7 = ((f3 == 3'b000 || f3 == 3'b101) && ($urandom % 2)) ? 7'h20 : 7'h00;
            case ($urandom % 8)
                0: begin
                    opc = 7'($urandom);
                    if (opc inside {OP, OP_IMM, LUI, AUIPC}) opc[0] = 1'b0;
                    prog[i] = {25'($urandom), opc};
                end
                1, 2, 3: prog[i] = {f7, rs2, rs1, f3, rd, OP};
                4, 5: begin
                    if (f3 == 3'b001) imm12[11:5] = 7'h00;
                    if (f3 == 3'b101) imm12[11:5] = f7;
                    prog[i] = {imm12, rs1, f3, rd, OP_IMM};
                end
                6: prog[i] = {20'($urandom), rd, LUI};
                default: prog[i] = {20'($urandom), rd, AUIPC};
            endcase
        end
    endtask

    task automatic build_expected();
        word_t     regs [`CORE_NREGS];
        word_t     inst;
        word_t     pc;
        word_t     res;
        reg_addr_t rd;
        logic      ok;
        foreach (regs[r]) regs[r] = '0;
        for (int i = 0; i < PROG_WORDS; i++) begin
            inst = prog[i];
            pc = `CORE_RESET_PC + word_t'(4 * i);
            rd = inst[11:7];
            ok = 1'b1;
            res = '0;
            case (inst[6:0])
                OP: res = isa_alu(inst[14:12], inst[30], regs[inst[19:15]], regs[inst[24:20]]);
                OP_IMM: res = isa_alu(inst[14:12], inst[14:12] == 3'b101 && inst[30],
                                      regs[inst[19:15]], {{20{inst[31]}}, inst[31:20]});
                LUI: res = {inst[31:12], 12'h000};
                AUIPC: res = pc + {inst[31:12], 12'h000};
                default: ok = 1'b0;
            endcase
            if (ok) begin
                exp_pc.push_back(pc);
                exp_rd.push_back(word_t'(rd));
                exp_val.push_back(res);
                if (rd != '0) regs[rd] = res;
            end
        end
    endtask

    function automatic word_t read_word(word_t addr);
        if ((addr >> 2) < PROG_WORDS) return prog[addr >> 2];
        // opcode field zero past the program, so these words are bubbles
        return {addr[24:0] ^ addr[31:7], 7'h00};
    endfunction

    // instruction memory with in-order answers after 1 to 3 cycles
    always @(posedge CLK) begin
        int unsigned due;
        if (!RST) begin
            if (pend_due.size() > 0 && pend_due[0] == cycle) begin
                inst_rvalid <= 1'b1;
                inst_rdata <= read_word(pend_addr.pop_front());
                void'(pend_due.pop_front());
            end else begin
                inst_rvalid <= 1'b0;
            end
            if (inst_rden && !mem_wait) begin
                check_value("fetch address", inst_raddr, next_addr);
                next_addr = next_addr + 32'd4;
                due = cycle + 1 + ($urandom % 3);
                if (pend_due.size() > 0 && due <= pend_due[$]) due = pend_due[$] + 1;
                pend_addr.push_back(inst_raddr);
                pend_due.push_back(due);
            end
            mem_wait <= ($urandom % 4 == 0);
            cycle++;
        end
    end

    // retire port is stable at the falling edge
    always @(negedge CLK) begin
        if (!RST && wb_valid) begin
            if (exp_pc.size() == 0) begin
                other_errors++;
                $display("unexpected retirement of pc %h at time %0t", wb_pc, $time);
            end else begin
                check_value($sformatf("pc of retirement %0d", retired), wb_pc, exp_pc[0]);
                check_value($sformatf("rd of pc %h", exp_pc[0]), word_t'(wb_rd), exp_rd[0]);
                check_value($sformatf("result of pc %h", exp_pc[0]), wb_data, exp_val[0]);
                void'(exp_pc.pop_front());
                void'(exp_rd.pop_front());
                void'(exp_val.pop_front());
                retired++;
            end
        end
    end

    initial begin
        int unsigned wait_cycles;
        void'($urandom(32'he8f5));
        make_program();
        build_expected();
        repeat (8) @(posedge CLK);
        RST <= 1'b0;
        wait_cycles = 0;
        while (exp_pc.size() > 0 && wait_cycles < TIMEOUT_CYCLES) begin
            @(posedge CLK);
            wait_cycles++;
        end
        if (exp_pc.size() > 0) begin
            other_errors++;
            $display("timeout: %0d instructions never retired", exp_pc.size());
        end
        // a few more cycles to catch stray retirements
        repeat (10) @(negedge CLK);
        $display("summary: %0d retired, %0d value errors, %0d other errors, %0d assertion failures",
                 retired, value_errors, other_errors, i_core.u_core_chk.fail_count);
        if (value_errors == 0 && other_errors == 0 && i_core.u_core_chk.fail_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/core_chk.sv
`default_nettype none

module core_chk import core_pkg::*; (
    input wire        CLK,
    input wire        RST,
    input wire        mem_wait,
    input wire        inst_rden,
    input wire word_t inst_raddr,
    input wire        inst_rvalid,
    input wire word_t inst_rdata,
    input wire        wb_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;
    logic        rdata_supported;

    assign rdata_supported = inst_rdata[6:0] inside {OP, OP_IMM, LUI, AUIPC};

    // request must not move while the memory holds it
    hold_request: assert property (@(posedge CLK) disable iff (RST)
        (inst_rden && mem_wait) |=> (inst_rden && $stable(inst_raddr)))
        else begin
            fail_count++;
            $error("instruction request changed while mem_wait was high");
        end

    step_by_four: assert property (@(posedge CLK) disable iff (RST)
        (inst_rden && !mem_wait) |=> (inst_raddr == $past(inst_raddr) + 32'd4))
        else begin
            fail_count++;
            $error("fetch address did not advance by 4 after an accepted request");
        end

    // supported words retire exactly three edges after their data
    retire_in_three: assert property (@(posedge CLK) disable iff (RST)
        (inst_rvalid && rdata_supported) |-> ##3 wb_valid)
        else begin
            fail_count++;
            $error("supported instruction did not retire three cycles after inst_rvalid");
        end

    bubble_in_three: assert property (@(posedge CLK) disable iff (RST)
        (inst_rvalid && !rdata_supported) |-> ##3 !wb_valid)
        else begin
            fail_count++;
            $error("unsupported instruction retired");
        end

    no_stray_retire: assert property (@(posedge CLK) disable iff (RST)
        wb_valid |-> $past(inst_rvalid, 3))
        else begin
            fail_count++;
            $error("retirement without a returned instruction three cycles earlier");
        end

endmodule

bind core core_chk u_core_chk (
    .CLK         (CLK),
    .RST         (RST),
    .mem_wait    (mem_wait),
    .inst_rden   (inst_rden),
    .inst_raddr  (inst_raddr),
    .inst_rvalid (inst_rvalid),
    .inst_rdata  (inst_rdata),
    .wb_valid    (wb_valid)
);

`default_nettype wire

//--- logic/core.sv
`default_nettype none

module core import core_pkg::*; (
    input  wire        CLK,
    input  wire        RST,
    input  wire        mem_wait,
    input  wire        inst_rvalid,
    input  wire word_t inst_rdata,
    output logic       inst_rden,
    output word_t      inst_raddr,
    output logic       wb_valid,
    output reg_addr_t  wb_rd,
    output word_t      wb_data,
    output word_t      wb_pc
);

    // fetch to first decode
    logic      fetch_valid;
    word_t     fetch_pc;
    word_t     fetch_inst;

    // first to second decode
    logic      d1_valid;
    word_t     d1_pc;
    logic [6:0] d1_opcode;
    reg_addr_t d1_rd;
    reg_addr_t d1_rs1;
    reg_addr_t d1_rs2;
    funct3_t   d1_funct3;
    funct7_t   d1_funct7;
    word_t     d1_imm_i;
    word_t     d1_imm_s;
    word_t     d1_imm_b;
    word_t     d1_imm_u;
    word_t     d1_imm_j;

    // register reads
    reg_addr_t rf_rs1;
    reg_addr_t rf_rs2;
    word_t     rs1_val;
    word_t     rs2_val;

    // second decode to execute
    logic      d2_valid;
    word_t     d2_pc;
    reg_addr_t d2_rd;
    reg_addr_t d2_rs1;
    reg_addr_t d2_rs2;
    alu_op_e   d2_alu_op;
    word_t     d2_opa;
    word_t     d2_opb;
    logic      d2_use_rs1;
    logic      d2_use_rs2;

    fetch_ctrl u_fetch_ctrl (
        .CLK         (CLK),
        .RST         (RST),
        .mem_wait    (mem_wait),
        .inst_rvalid (inst_rvalid),
        .inst_rdata  (inst_rdata),
        .inst_rden   (inst_rden),
        .inst_raddr  (inst_raddr),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .fetch_inst  (fetch_inst)
    );

    decode_1st u_decode_1st (
        .CLK         (CLK),
        .RST         (RST),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .fetch_inst  (fetch_inst),
        .d1_valid    (d1_valid),
        .d1_pc       (d1_pc),
        .d1_opcode   (d1_opcode),
        .d1_rd       (d1_rd),
        .d1_rs1      (d1_rs1),
        .d1_rs2      (d1_rs2),
        .d1_funct3   (d1_funct3),
        .d1_funct7   (d1_funct7),
        .d1_imm_i    (d1_imm_i),
        .d1_imm_s    (d1_imm_s),
        .d1_imm_b    (d1_imm_b),
        .d1_imm_u    (d1_imm_u),
        .d1_imm_j    (d1_imm_j)
    );

    decode_2nd u_decode_2nd (
        .CLK        (CLK),
        .RST        (RST),
        .d1_valid   (d1_valid),
        .d1_pc      (d1_pc),
        .d1_opcode  (d1_opcode),
        .d1_rd      (d1_rd),
        .d1_rs1     (d1_rs1),
        .d1_rs2     (d1_rs2),
        .d1_funct3  (d1_funct3),
        .d1_funct7  (d1_funct7),
        .d1_imm_i   (d1_imm_i),
        .d1_imm_s   (d1_imm_s),
        .d1_imm_b   (d1_imm_b),
        .d1_imm_u   (d1_imm_u),
        .d1_imm_j   (d1_imm_j),
        .rs1_val    (rs1_val),
        .rs2_val    (rs2_val),
        .rf_rs1     (rf_rs1),
        .rf_rs2     (rf_rs2),
        .d2_valid   (d2_valid),
        .d2_pc      (d2_pc),
        .d2_rd      (d2_rd),
        .d2_rs1     (d2_rs1),
        .d2_rs2     (d2_rs2),
        .d2_alu_op  (d2_alu_op),
        .d2_opa     (d2_opa),
        .d2_opb     (d2_opb),
        .d2_use_rs1 (d2_use_rs1),
        .d2_use_rs2 (d2_use_rs2)
    );

    register_file u_register_file (
        .CLK      (CLK),
        .RST      (RST),
        .rf_rs1   (rf_rs1),
        .rf_rs2   (rf_rs2),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .rs1_val  (rs1_val),
        .rs2_val  (rs2_val)
    );

    exec u_exec (
        .CLK        (CLK),
        .RST        (RST),
        .d2_valid   (d2_valid),
        .d2_pc      (d2_pc),
        .d2_rd      (d2_rd),
        .d2_rs1     (d2_rs1),
        .d2_rs2     (d2_rs2),
        .d2_alu_op  (d2_alu_op),
        .d2_opa     (d2_opa),
        .d2_opb     (d2_opb),
        .d2_use_rs1 (d2_use_rs1),
        .d2_use_rs2 (d2_use_rs2),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .wb_pc      (wb_pc)
    );

endmodule

`default_nettype wire

//--- logic/exec.sv
`default_nettype none

module exec import core_pkg::*; (
    input  wire            CLK,
    input  wire            RST,
    input  wire            d2_valid,
    input  wire word_t     d2_pc,
    input  wire reg_addr_t d2_rd,
    input  wire reg_addr_t d2_rs1,
    input  wire reg_addr_t d2_rs2,
    input  wire alu_op_e   d2_alu_op,
    input  wire word_t     d2_opa,
    input  wire word_t     d2_opb,
    input  wire            d2_use_rs1,
    input  wire            d2_use_rs2,
    output logic           wb_valid,
    output reg_addr_t      wb_rd,
    output word_t          wb_data,
    output word_t          wb_pc
);

    logic  prev_wr;
    logic  fwd_a;
    logic  fwd_b;
    word_t opa;
    word_t opb;
    word_t result;

    // producer one instruction ahead sits in the result register
    assign prev_wr = wb_valid && (wb_rd != '0);
    assign fwd_a   = prev_wr && d2_use_rs1 && (wb_rd == d2_rs1);
    assign fwd_b   = prev_wr && d2_use_rs2 && (wb_rd == d2_rs2);
    assign opa     = fwd_a ? wb_data : d2_opa;
    assign opb     = fwd_b ? wb_data : d2_opb;

    always_comb begin
        case (d2_alu_op)
            ALU_ADD:    result = opa + opb;
            ALU_SUB:    result = opa - opb;
            ALU_SLL:    result = opa << opb[4:0];
            ALU_SLT:    result = word_t'($signed(opa) < $signed(opb));
            ALU_SLTU:   result = word_t'(opa < opb);
            ALU_XOR:    result = opa ^ opb;
            ALU_SRL:    result = opa >> opb[4:0];
            ALU_SRA:    result = word_t'($signed(opa) >>> opb[4:0]);
            ALU_OR:     result = opa | opb;
            ALU_AND:    result = opa & opb;
            ALU_PASS_B: result = opb;
            default:    result = '0;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= d2_valid;
        end
    end

    // payload only loads for a valid instruction
    always_ff @(posedge CLK) begin
        if (d2_valid) begin
            wb_rd   <= d2_rd;
            wb_data <= result;
            wb_pc   <= d2_pc;
        end
    end

endmodule

`default_nettype wire

//--- logic/register_file.sv
`default_nettype none

`include "core_consts.svh"

module register_file import core_pkg::*; (
    input  wire            CLK,
    input  wire            RST,
    input  wire reg_addr_t rf_rs1,
    input  wire reg_addr_t rf_rs2,
    input  wire            wb_valid,
    input  wire reg_addr_t wb_rd,
    input  wire word_t     wb_data,
    output word_t          rs1_val,
    output word_t          rs2_val
);

    // x0 has no storage
    word_t regs [1:`CORE_NREGS-1];
    logic  wr_en;

    assign wr_en = wb_valid && (wb_rd != '0);

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 1; i < `CORE_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // same-cycle write goes straight to the reader
    assign rs1_val = (rf_rs1 == '0) ? '0 :
                     (wr_en && wb_rd == rf_rs1) ? wb_data : regs[rf_rs1];
    assign rs2_val = (rf_rs2 == '0) ? '0 :
                     (wr_en && wb_rd == rf_rs2) ? wb_data : regs[rf_rs2];

endmodule

`default_nettype wire

//--- logic/decode_2nd.sv
`default_nettype none

module decode_2nd import core_pkg::*; (
    input  wire            CLK,
    input  wire            RST,
    input  wire            d1_valid,
    input  wire word_t     d1_pc,
    input  wire [6:0]      d1_opcode,
    input  wire reg_addr_t d1_rd,
    input  wire reg_addr_t d1_rs1,
    input  wire reg_addr_t d1_rs2,
    input  wire funct3_t   d1_funct3,
    input  wire funct7_t   d1_funct7,
    input  wire word_t     d1_imm_i,
    input  wire word_t     d1_imm_s,
    input  wire word_t     d1_imm_b,
    input  wire word_t     d1_imm_u,
    input  wire word_t     d1_imm_j,
    input  wire word_t     rs1_val,
    input  wire word_t     rs2_val,
    output reg_addr_t      rf_rs1,
    output reg_addr_t      rf_rs2,
    output logic           d2_valid,
    output word_t          d2_pc,
    output reg_addr_t      d2_rd,
    output reg_addr_t      d2_rs1,
    output reg_addr_t      d2_rs2,
    output alu_op_e        d2_alu_op,
    output word_t          d2_opa,
    output word_t          d2_opb,
    output logic           d2_use_rs1,
    output logic           d2_use_rs2
);

    logic    is_op;
    logic    is_op_imm;
    logic    is_lui;
    logic    is_auipc;
    word_t   imm;
    alu_op_e alu_op;

    assign is_op     = (d1_opcode == OP);
    assign is_op_imm = (d1_opcode == OP_IMM);
    assign is_lui    = (d1_opcode == LUI);
    assign is_auipc  = (d1_opcode == AUIPC);

    // register file is read during this stage
    assign rf_rs1 = d1_rs1;
    assign rf_rs2 = d1_rs2;

    // store, branch and jal formats are ready for later extensions
    always_comb begin
        case (d1_opcode)
            LUI, AUIPC: imm = d1_imm_u;
            7'b0100011: imm = d1_imm_s;
            7'b1100011: imm = d1_imm_b;
            7'b1101111: imm = d1_imm_j;
            default:    imm = d1_imm_i;
        endcase
    end

    always_comb begin
        alu_op = ALU_ADD;
        if (is_lui) begin
            alu_op = ALU_PASS_B;
        end else if (is_op || is_op_imm) begin
            case (d1_funct3)
                3'b000: alu_op = (is_op && d1_funct7[5]) ? ALU_SUB : ALU_ADD;
                3'b001: alu_op = ALU_SLL;
                3'b010: alu_op = ALU_SLT;
                3'b011: alu_op = ALU_SLTU;
                3'b100: alu_op = ALU_XOR;
                // imm shifts keep the arithmetic flag in the same bit
                3'b101: alu_op = d1_funct7[5] ? ALU_SRA : ALU_SRL;
                3'b110: alu_op = ALU_OR;
                default: alu_op = ALU_AND;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            d2_valid <= 1'b0;
        end else begin
            // unsupported opcodes become bubbles here
            d2_valid <= d1_valid && (is_op || is_op_imm || is_lui || is_auipc);
        end
    end

    always_ff @(posedge CLK) begin
        d2_pc      <= d1_pc;
        d2_rd      <= d1_rd;
        d2_rs1     <= d1_rs1;
        d2_rs2     <= d1_rs2;
        d2_alu_op  <= alu_op;
        d2_opa     <= is_auipc ? d1_pc : (is_lui ? '0 : rs1_val);
        d2_opb     <= is_op ? rs2_val : imm;
        d2_use_rs1 <= is_op || is_op_imm;
        d2_use_rs2 <= is_op;
    end

endmodule

`default_nettype wire

//--- logic/decode_1st.sv
`default_nettype none

module decode_1st import core_pkg::*; (
    input  wire        CLK,
    input  wire        RST,
    input  wire        fetch_valid,
    input  wire word_t fetch_pc,
    input  wire word_t fetch_inst,
    output logic       d1_valid,
    output word_t      d1_pc,
    output logic [6:0] d1_opcode,
    output reg_addr_t  d1_rd,
    output reg_addr_t  d1_rs1,
    output reg_addr_t  d1_rs2,
    output funct3_t    d1_funct3,
    output funct7_t    d1_funct7,
    output word_t      d1_imm_i,
    output word_t      d1_imm_s,
    output word_t      d1_imm_b,
    output word_t      d1_imm_u,
    output word_t      d1_imm_j
);

    always_ff @(posedge CLK) begin
        if (RST) begin
            d1_valid <= 1'b0;
        end else begin
            d1_valid <= fetch_valid;
        end
    end

    // fixed field positions of the base encoding
    always_ff @(posedge CLK) begin
        d1_pc     <= fetch_pc;
        d1_opcode <= fetch_inst[6:0];
        d1_rd     <= fetch_inst[11:7];
        d1_funct3 <= fetch_inst[14:12];
        d1_rs1    <= fetch_inst[19:15];
        d1_rs2    <= fetch_inst[24:20];
        d1_funct7 <= fetch_inst[31:25];
    end

    // sign bit of every immediate form is inst[31]
    always_ff @(posedge CLK) begin
        d1_imm_i <= {{20{fetch_inst[31]}}, fetch_inst[31:20]};
        d1_imm_s <= {{20{fetch_inst[31]}}, fetch_inst[31:25], fetch_inst[11:7]};
        d1_imm_b <= {{19{fetch_inst[31]}}, fetch_inst[31], fetch_inst[7],
                     fetch_inst[30:25], fetch_inst[11:8], 1'b0};
        d1_imm_u <= {fetch_inst[31:12], 12'h000};
        d1_imm_j <= {{11{fetch_inst[31]}}, fetch_inst[31], fetch_inst[19:12],
                     fetch_inst[20], fetch_inst[30:21], 1'b0};
    end

endmodule

`default_nettype wire

//--- logic/fetch_ctrl.sv
`default_nettype none

`include "core_consts.svh"

module fetch_ctrl import core_pkg::*; (
    input  wire        CLK,
    input  wire        RST,
    input  wire        mem_wait,
    input  wire        inst_rvalid,
    input  wire word_t inst_rdata,
    output logic       inst_rden,
    output word_t      inst_raddr,
    output logic       fetch_valid,
    output word_t      fetch_pc,
    output word_t      fetch_inst
);

    fetch_state_e state;
    logic         req_accept;

    // addresses of requests still waiting for their data
    word_t        pend_q [4];
    logic [1:0]   wr_ptr;
    logic [1:0]   rd_ptr;

    assign req_accept = inst_rden && !mem_wait;

    always_ff @(posedge CLK) begin
        if (RST) begin
            state      <= RESET_WAIT;
            inst_rden  <= 1'b0;
            inst_raddr <= `CORE_RESET_PC;
        end else begin
            case (state)
                RESET_WAIT: begin
                    state     <= RUN;
                    inst_rden <= 1'b1;
                end
                RUN: begin
                    // hold address and enable while the memory waits
                    if (req_accept) begin
                        inst_raddr <= inst_raddr + word_t'(4);
                    end
                end
                default: state <= RESET_WAIT;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (req_accept) begin
            pend_q[wr_ptr] <= inst_raddr;
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (req_accept) begin
                wr_ptr <= wr_ptr + 2'd1;
            end
            if (inst_rvalid) begin
                rd_ptr <= rd_ptr + 2'd1;
            end
        end
    end

    // memory answers in order, so the oldest address belongs to this word
    assign fetch_valid = inst_rvalid;
    assign fetch_pc    = pend_q[rd_ptr];
    assign fetch_inst  = inst_rdata;

endmodule

`default_nettype wire

//--- logic/core_pkg.sv
`default_nettype none

`include "core_consts.svh"

package core_pkg;

    typedef logic [`CORE_XLEN-1:0]   word_t;
    typedef logic [`CORE_REG_AW-1:0] reg_addr_t;
    typedef logic [2:0]              funct3_t;
    typedef logic [6:0]              funct7_t;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    typedef enum logic {
        RESET_WAIT,
        RUN
    } fetch_state_e;

endpackage

`default_nettype wire

//--- logic/core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// data and address width
`define CORE_XLEN 32

// register index width
`define CORE_REG_AW 5

// x0 to x31
`define CORE_NREGS 32

// first fetch address after reset
`define CORE_RESET_PC 32'h0000_0000

`endif
